// File: calc_exe_pipe.sv
//**************************************************************************
// Fixed-latency pipe: one-cycle ALU, three-cycle multiplier (low half of
// the product only). Every result writes back from stage 3, exactly three
// edges after dispatch. Divide ops pass through without occupying a stage.
//**************************************************************************
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_exe_pipe
  (input  logic                 clk_i
  , input  logic                arst_n_i
  , input  calc_pkg::calc_rsv_s rsv_i
  , input  logic                flush_i
  , calc_fwd_if.source          fwd
  , calc_wb_if.producer         wb
  );
  import calc_pkg::*;

  localparam int half_w    = `CALC_XLEN / 2;
  localparam int mul_stage = `CALC_FWD_STAGES;

  calc_stage_s [`CALC_FWD_STAGES:1] stage_n;
  calc_stage_s [`CALC_FWD_STAGES:1] stage_r;

  calc_data_t        alu_res;
  logic              fixed_op;
  calc_data_t        mul_a_r;
  calc_data_t        mul_b_r;
  calc_data_t        pp_ll_r;
  logic [half_w-1:0] pp_lh_r;
  logic [half_w-1:0] pp_hl_r;
  calc_data_t        mul_res;

  always_comb
  begin
    case (rsv_i.op)
      CALC_ADD: alu_res = rsv_i.rs1 + rsv_i.rs2;
      CALC_SUB: alu_res = rsv_i.rs1 - rsv_i.rs2;
      CALC_AND: alu_res = rsv_i.rs1 & rsv_i.rs2;
      CALC_XOR: alu_res = rsv_i.rs1 ^ rsv_i.rs2;
      default:  alu_res = '0;
    endcase
  end

  assign fixed_op = !(rsv_i.op inside {CALC_DIVU, CALC_REMU});

  // Operand capture, then partial products; cross terms only need low halves
  always_ff @(posedge clk_i)
  begin
    mul_a_r <= rsv_i.rs1;
    mul_b_r <= rsv_i.rs2;
    pp_ll_r <= mul_a_r[half_w-1:0] * mul_b_r[half_w-1:0];
    pp_lh_r <= mul_a_r[half_w-1:0] * mul_b_r[`CALC_XLEN-1:half_w];
    pp_hl_r <= mul_a_r[`CALC_XLEN-1:half_w] * mul_b_r[half_w-1:0];
  end

  assign mul_res = pp_ll_r + {pp_lh_r + pp_hl_r, {half_w{1'b0}}};

  always_comb
  begin
    stage_n[1].v      = rsv_i.v & fixed_op;
    stage_n[1].poison = flush_i;
    stage_n[1].mul    = (rsv_i.op == CALC_MUL);
    stage_n[1].rd     = rsv_i.rd;
    stage_n[1].data   = alu_res;
    for (int i = 2; i <= `CALC_FWD_STAGES; i++)
    begin
      stage_n[i] = stage_r[i-1];
    end
    stage_n[2].poison = stage_r[1].poison | flush_i;
    if (stage_r[mul_stage-1].mul)
      stage_n[mul_stage].data = mul_res;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      stage_r <= '0;
    else
      stage_r <= stage_n;
  end

  // A multiply has no usable data before the last stage
  always_comb
  begin
    for (int i = 1; i <= `CALC_FWD_STAGES; i++)
    begin
      fwd.v[i-1]    = stage_n[i].v & ~stage_n[i].poison & (~stage_n[i].mul | (i == mul_stage));
      fwd.rd[i-1]   = stage_n[i].rd;
      fwd.data[i-1] = stage_n[i].data;
    end
  end

  assign wb.v       = stage_r[`CALC_FWD_STAGES].v & ~stage_r[`CALC_FWD_STAGES].poison;
  assign wb.rd_addr = stage_r[`CALC_FWD_STAGES].rd;
  assign wb.data    = stage_r[`CALC_FWD_STAGES].data;

endmodule

// File: calc_fwd_if.sv
//**************************************************************************
// Results still in flight, one slot per completion stage.
// Slot 0 holds the youngest result and has the highest bypass priority.
//**************************************************************************
`timescale 1ns/1ps
`include "calc_params.svh"

interface calc_fwd_if;
  logic [`CALC_FWD_STAGES-1:0]                        v;
  logic [`CALC_FWD_STAGES-1:0][`CALC_REG_AW-1:0] rd;
  logic [`CALC_FWD_STAGES-1:0][`CALC_XLEN-1:0]   data;

  // Sampled by the issue stage in the same cycle
  modport source (output v, rd, data);
  modport sink (input v, rd, data);
endinterface

// File: calc_issue.sv
//**************************************************************************
// Operand bypass and reservation register. A flush during the cycle an
// entry sits in the reservation register hides it from both pipes.
//**************************************************************************
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_issue
  (input  logic                  clk_i
  , input  logic                 arst_n_i
  , input  logic                 dispatch_v_i
  , input  calc_pkg::calc_op_e   op_i
  , input  calc_pkg::calc_reg_t  rd_i
  , input  calc_pkg::calc_reg_t  rs1_addr_i
  , input  calc_pkg::calc_reg_t  rs2_addr_i
  , input  calc_pkg::calc_data_t rs1_data_i
  , input  calc_pkg::calc_data_t rs2_data_i
  , input  logic                 flush_i
  , calc_fwd_if.sink             fwd
  , output calc_pkg::calc_rsv_s  rsv_o
  );
  import calc_pkg::*;

  calc_rsv_s rsv_n;
  calc_rsv_s rsv_r;
  logic      rsv_v_r;

  // Oldest stage first so the youngest match wins
  always_comb
  begin
    rsv_n.v   = dispatch_v_i;
    rsv_n.op  = op_i;
    rsv_n.rd  = rd_i;
    rsv_n.rs1 = rs1_data_i;
    rsv_n.rs2 = rs2_data_i;
    for (int i = `CALC_FWD_STAGES-1; i >= 0; i--)
    begin
      if (fwd.v[i] && (fwd.rd[i] == rs1_addr_i))
        rsv_n.rs1 = fwd.data[i];
      if (fwd.v[i] && (fwd.rd[i] == rs2_addr_i))
        rsv_n.rs2 = fwd.data[i];
    end
    if (rs1_addr_i == '0)
      rsv_n.rs1 = '0;
    if (rs2_addr_i == '0)
      rsv_n.rs2 = '0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rsv_v_r <= 1'b0;
    else
      rsv_v_r <= dispatch_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    rsv_r <= rsv_n;
  end

  always_comb
  begin
    rsv_o   = rsv_r;
    rsv_o.v = rsv_v_r & ~flush_i;
  end

  a_rsv_op_legal : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsv_v_r |-> rsv_r.op inside {CALC_ADD, CALC_SUB, CALC_AND, CALC_XOR,
                                 CALC_MUL, CALC_DIVU, CALC_REMU});

endmodule

// File: calc_long_div.sv
//**************************************************************************
// Restoring unsigned divider, one quotient bit per cycle. Takes one op at
// a time; busy_o stays high from acceptance until the result transfers.
// Divide by zero yields all ones and the dividend as remainder.
//**************************************************************************
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_long_div
  (input  logic                 clk_i
  , input  logic                arst_n_i
  , input  calc_pkg::calc_rsv_s rsv_i
  , calc_wb_if.producer         wb
  , output logic                busy_o
  );
  import calc_pkg::*;

  localparam int cnt_w = $clog2(`CALC_DIV_ITERS + 1);

  logic               busy_r;
  logic               done_r;
  logic [cnt_w-1:0]   cnt_r;
  logic               start;
  logic               is_rem_r;
  calc_reg_t          rd_r;
  calc_data_t         quo_r;
  calc_data_t         rem_r;
  calc_data_t         div_r;
  logic [`CALC_XLEN:0] rem_shift;
  logic [`CALC_XLEN:0] diff;

  assign start     = rsv_i.v & (rsv_i.op inside {CALC_DIVU, CALC_REMU}) & ~busy_r;
  assign rem_shift = {rem_r, quo_r[`CALC_XLEN-1]};
  assign diff      = rem_shift - {1'b0, div_r};

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (start)
    begin
      busy_r <= 1'b1;
      cnt_r  <= cnt_w'(`CALC_DIV_ITERS);
    end
    else if (busy_r && !done_r)
    begin
      cnt_r  <= cnt_r - 1'b1;
      done_r <= (cnt_r == 1);
    end
    else if (done_r && wb.ready)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end
  end

  // Dividend shifts out of quo_r as quotient bits shift in
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      quo_r    <= rsv_i.rs1;
      div_r    <= rsv_i.rs2;
      rem_r    <= '0;
      rd_r     <= rsv_i.rd;
      is_rem_r <= (rsv_i.op == CALC_REMU);
    end
    else if (busy_r && !done_r)
    begin
      if (!diff[`CALC_XLEN])
      begin
        rem_r <= diff[`CALC_XLEN-1:0];
        quo_r <= {quo_r[`CALC_XLEN-2:0], 1'b1};
      end
      else
      begin
        rem_r <= rem_shift[`CALC_XLEN-1:0];
        quo_r <= {quo_r[`CALC_XLEN-2:0], 1'b0};
      end
    end
  end

  assign wb.v       = done_r;
  assign wb.rd_addr = rd_r;
  assign wb.data    = is_rem_r ? rem_r : quo_r;
  assign busy_o     = busy_r;

  // Dispatcher must wait for long_busy to drop
  a_no_div_when_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsv_i.v && (rsv_i.op inside {CALC_DIVU, CALC_REMU})) |-> !busy_r);

endmodule

// File: calc_params.svh
//**************************************************************************
// Sizing for the integer execution core. CALC_DIV_ITERS must stay equal
// to CALC_XLEN, since the divider retires one quotient bit per step.
// CALC_FWD_STAGES is also the fixed pipe depth and the multiply latency.
//**************************************************************************
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

`define CALC_XLEN 32
`define CALC_REG_AW 5

`define CALC_FWD_STAGES 3
`define CALC_DIV_ITERS `CALC_XLEN

`endif

// File: calc_patterns.txt
// op_rd_rs1_rs2_flush_kill_value, op 7 loads an initial register value
// op 0 add, 1 sub, 2 and, 3 xor, 4 mul, 5 divu, 6 remu
7_01_00_00_0_0_00000005
7_02_00_00_0_0_00000003
7_03_00_00_0_0_12345678
7_04_00_00_0_0_0000FFFF
7_05_00_00_0_0_00000007
7_06_00_00_0_0_F0F0F0F0
5_11_03_02_0_0_06117228
0_07_01_02_0_0_00000008
1_08_07_01_0_0_00000003
3_09_08_07_0_0_0000000B
2_0A_03_04_0_0_00005678
0_00_01_02_0_0_00000008
0_0B_00_01_0_0_00000005
4_0C_03_04_0_0_4443A988
3_0D_01_06_0_0_F0F0F0F5
2_0E_02_04_0_0_00000003
0_0F_0C_01_0_0_4443A98D
4_10_07_07_0_0_00000040
1_12_09_0A_0_0_FFFFA993
3_13_0D_0E_0_0_F0F0F0F6
0_14_10_0B_0_0_00000045
6_15_03_05_0_0_00000005
0_16_11_01_0_0_0611722D
3_18_06_04_0_0_F0F00F0F
0_19_01_01_0_1_0000000A
2_1A_03_06_1_1_10305070
0_1B_02_02_0_0_00000006
5_1C_03_00_0_0_FFFFFFFF
6_1D_04_00_0_0_0000FFFF
1_1E_15_02_0_0_00000002
0_1F_1C_1D_0_0_0000FFFE

// File: calc_pkg.sv
//**************************************************************************
// Operation codes and packet types shared by the execution core.
// Op codes 3'b111 is unused and never legal in a valid reservation.
//**************************************************************************
`include "calc_params.svh"

package calc_pkg;

  typedef logic [`CALC_XLEN-1:0]   calc_data_t;
  typedef logic [`CALC_REG_AW-1:0] calc_reg_t;

  typedef enum logic [2:0]
  {
    CALC_ADD  = 3'd0,
    CALC_SUB  = 3'd1,
    CALC_AND  = 3'd2,
    CALC_XOR  = 3'd3,
    CALC_MUL  = 3'd4,
    CALC_DIVU = 3'd5,
    CALC_REMU = 3'd6
  } calc_op_e;

  // Operands are already bypassed when this is registered
  typedef struct packed
  {
    logic       v;
    calc_op_e   op;
    calc_reg_t  rd;
    calc_data_t rs1;
    calc_data_t rs2;
  } calc_rsv_s;

  typedef struct packed
  {
    logic       v;
    logic       poison;
    logic       mul;
    calc_reg_t  rd;
    calc_data_t data;
  } calc_stage_s;

endpackage

// File: calc_tb.sv
//**************************************************************************
// Replays calc_patterns.txt against calc_top. Operands come from a register
// model with write-through from the writeback port. Fixed-pipe results are
// expected exactly four edges after the drive edge, a divide in the first
// slot the fixed pipe leaves free after its latency.
//**************************************************************************
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_tb;
  import calc_pkg::*;

  typedef struct
  {
    int         due;
    calc_reg_t  rd;
    calc_data_t val;
  } exp_s;

  logic       clk_i;
  logic       arst_n_i;
  logic       dispatch_v_i;
  calc_op_e   op_i;
  calc_reg_t  rd_i;
  calc_reg_t  rs1_addr_i;
  calc_reg_t  rs2_addr_i;
  calc_data_t rs1_data_i;
  calc_data_t rs2_data_i;
  logic       flush_i;
  logic       iwb_v_o;
  calc_reg_t  iwb_rd_o;
  calc_data_t iwb_data_o;
  logic       long_busy_o;

  logic [67:0] pat [0:63];
  calc_data_t  regs [0:31];
  exp_s        fixed_q [$];
  exp_s        div_q [$];
  int          n_lines;
  int          cyc;
  int          data_errs;
  int          reg_errs;
  int          busy_errs;
  int          other_errs;
  logic        flush_next;
  logic [31:0] rng;

  calc_top dut_i (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Register file read with write-through of the current writeback
  function automatic calc_data_t read_reg(input calc_reg_t a);
    if (a == '0)
      return '0;
    if (iwb_v_o && (iwb_rd_o == a))
      return iwb_data_o;
    return regs[a];
  endfunction

  task automatic check_data(input string name, input calc_data_t got, input calc_data_t exp);
    if (got !== exp)
    begin
      $display("error %s: got %h expected %h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_reg(input string name, input calc_reg_t got, input calc_reg_t exp);
    if (got !== exp)
    begin
      $display("error %s: got %h expected %h", name, got, exp);
      reg_errs++;
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error long_busy_o: got %h expected %h at cycle %0d", got, exp, cyc);
      busy_errs++;
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
    dispatch_v_i = 1'b0;
    flush_i      = flush_next;
    flush_next   = 1'b0;
  endtask

  always @(posedge clk_i)
  begin
    if (arst_n_i)
    begin
      cyc++;
      check_busy(long_busy_o, (div_q.size() > 0) && (cyc > div_q[0].due));
      while (fixed_q.size() > 0 && fixed_q[0].due < cyc)
      begin
        $display("missing writeback for register %0d", fixed_q[0].rd);
        other_errs++;
        void'(fixed_q.pop_front());
      end
      if (fixed_q.size() > 0 && fixed_q[0].due == cyc)
      begin
        if (!iwb_v_o)
        begin
          $display("missing writeback for register %0d at cycle %0d", fixed_q[0].rd, cyc);
          other_errs++;
        end
        else
        begin
          check_reg("iwb_rd_o", iwb_rd_o, fixed_q[0].rd);
          check_data("iwb_data_o", iwb_data_o, fixed_q[0].val);
        end
        void'(fixed_q.pop_front());
      end
      // Divide result is due in the first slot the fixed pipe leaves free
      else if (div_q.size() > 0 && cyc > div_q[0].due + `CALC_DIV_ITERS)
      begin
        if (!iwb_v_o)
        begin
          $display("missing divide writeback for register %0d at cycle %0d",
                   div_q[0].rd, cyc);
          other_errs++;
        end
        else
        begin
          check_reg("iwb_rd_o", iwb_rd_o, div_q[0].rd);
          check_data("iwb_data_o", iwb_data_o, div_q[0].val);
        end
        void'(div_q.pop_front());
      end
      else if (iwb_v_o)
      begin
        $display("unexpected writeback to register %0d at cycle %0d", iwb_rd_o, cyc);
        other_errs++;
      end
      if (iwb_v_o && iwb_rd_o != '0)
        regs[iwb_rd_o] = iwb_data_o;
    end
  end

  initial
  begin
    logic [67:0] w;
    logic        is_div;
    logic        aim_div;
    exp_s        e;
    dispatch_v_i = 1'b0;
    op_i         = CALC_ADD;
    rd_i         = '0;
    rs1_addr_i   = '0;
    rs2_addr_i   = '0;
    rs1_data_i   = '0;
    rs2_data_i   = '0;
    flush_i      = 1'b0;
    flush_next   = 1'b0;
    aim_div      = 1'b0;
    arst_n_i     = 1'b0;
    cyc          = 0;
    rng          = 32'd73172;
    // Op nibble F marks lines the file does not fill
    for (int i = 0; i < 64; i++)
      pat[i] = {4'hF, 64'(i)};
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    $readmemh("calc_patterns.txt", pat);
    n_lines = 0;
    while (n_lines < 64 && pat[n_lines][67:64] != 4'hF)
      n_lines++;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    for (int i = 0; i < n_lines; i++)
    begin
      w = pat[i];
      if (w[67:64] == 4'h7)
      begin
        regs[w[60:56]] = w[31:0];
        continue;
      end
      is_div = (w[66:64] == 3'd5) || (w[66:64] == 3'd6);
      // Divides run one at a time and their rd stays unread until written
      while (div_q.size() > 0 && (is_div || div_q[0].rd == w[52:48] || div_q[0].rd == w[44:40]))
        idle_cycle();
      // A flush needs the previous op still in stage 1
      if (!w[36])
      begin
        rng = xorshift32(rng);
        repeat (rng % 3) idle_cycle();
        // Hold the first fixed op after a divide so both results meet
        if (aim_div && !is_div)
        begin
          while (div_q.size() > 0 && cyc + 6 <= div_q[0].due + `CALC_DIV_ITERS)
            idle_cycle();
          aim_div = 1'b0;
        end
      end
      @(negedge clk_i);
      dispatch_v_i = 1'b1;
      op_i         = calc_op_e'(w[66:64]);
      rd_i         = w[60:56];
      rs1_addr_i   = w[52:48];
      rs2_addr_i   = w[44:40];
      rs1_data_i   = read_reg(w[52:48]);
      rs2_data_i   = read_reg(w[44:40]);
      flush_i      = flush_next;
      flush_next   = w[36];
      e.rd         = w[60:56];
      e.val        = w[31:0];
      e.due        = is_div ? cyc + 2 : cyc + 5;
      if (!w[32])
      begin
        if (is_div)
        begin
          div_q.push_back(e);
          aim_div = 1'b1;
        end
        else
          fixed_q.push_back(e);
      end
    end

    idle_cycle();
    while (fixed_q.size() > 0 || div_q.size() > 0)
      idle_cycle();
    repeat (8) idle_cycle();

    $display("errors: data %0d, reg %0d, busy %0d, other %0d",
             data_errs, reg_errs, busy_errs, other_errs);
    if (data_errs + reg_errs + busy_errs + other_errs == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #1;
    repeat (5 + n_lines * (`CALC_DIV_ITERS + 8)) @(posedge clk_i);
    $display("timeout, writebacks still pending after %0d cycles", cyc);
    $display("tests failed");
    $finish;
  end

endmodule

// File: calc_top.sv
//**************************************************************************
// Integer execution core, single issue. Register file lives outside; the
// dispatcher must respect long_busy_o and the multiply/divide hazard rules.
//**************************************************************************
`timescale 1ns/1ps

module calc_top
  (input  logic                  clk_i
  , input  logic                 arst_n_i
  , input  logic                 dispatch_v_i
  , input  calc_pkg::calc_op_e   op_i
  , input  calc_pkg::calc_reg_t  rd_i
  , input  calc_pkg::calc_reg_t  rs1_addr_i
  , input  calc_pkg::calc_reg_t  rs2_addr_i
  , input  calc_pkg::calc_data_t rs1_data_i
  , input  calc_pkg::calc_data_t rs2_data_i
  , input  logic                 flush_i
  , output logic                 iwb_v_o
  , output calc_pkg::calc_reg_t  iwb_rd_o
  , output calc_pkg::calc_data_t iwb_data_o
  , output logic                 long_busy_o
  );
  import calc_pkg::*;

  calc_rsv_s rsv;

  calc_wb_if  fixed_wb ();
  calc_wb_if  long_wb ();
  calc_fwd_if fwd ();

  calc_issue u_issue
    (.clk_i       (clk_i)
    , .arst_n_i   (arst_n_i)
    , .dispatch_v_i(dispatch_v_i)
    , .op_i       (op_i)
    , .rd_i       (rd_i)
    , .rs1_addr_i (rs1_addr_i)
    , .rs2_addr_i (rs2_addr_i)
    , .rs1_data_i (rs1_data_i)
    , .rs2_data_i (rs2_data_i)
    , .flush_i    (flush_i)
    , .fwd        (fwd.sink)
    , .rsv_o      (rsv)
    );

  calc_exe_pipe u_exe_pipe
    (.clk_i     (clk_i)
    , .arst_n_i (arst_n_i)
    , .rsv_i    (rsv)
    , .flush_i  (flush_i)
    , .fwd      (fwd.source)
    , .wb       (fixed_wb.producer)
    );

  calc_long_div u_long_div
    (.clk_i     (clk_i)
    , .arst_n_i (arst_n_i)
    , .rsv_i    (rsv)
    , .wb       (long_wb.producer)
    , .busy_o   (long_busy_o)
    );

  calc_wb_arbiter u_wb_arbiter
    (.clk_i       (clk_i)
    , .arst_n_i   (arst_n_i)
    , .fixed_wb   (fixed_wb.consumer)
    , .long_wb    (long_wb.consumer)
    , .iwb_v_o    (iwb_v_o)
    , .iwb_rd_o   (iwb_rd_o)
    , .iwb_data_o (iwb_data_o)
    );

endmodule

// File: calc_wb_arbiter.sv
//**************************************************************************
// Single integer writeback port. The fixed pipe has absolute priority and
// is never stalled; the divider waits for a free cycle.
//**************************************************************************
`timescale 1ns/1ps

module calc_wb_arbiter
  (input  logic                  clk_i
  , input  logic                 arst_n_i
  , calc_wb_if.consumer          fixed_wb
  , calc_wb_if.consumer          long_wb
  , output logic                 iwb_v_o
  , output calc_pkg::calc_reg_t  iwb_rd_o
  , output calc_pkg::calc_data_t iwb_data_o
  );

  logic grant_fixed;
  logic grant_long;

  assign grant_fixed = fixed_wb.v;
  assign grant_long  = long_wb.v & ~fixed_wb.v;

  assign fixed_wb.ready = 1'b1;
  assign long_wb.ready  = ~fixed_wb.v;

  assign iwb_v_o    = grant_fixed | grant_long;
  assign iwb_rd_o   = grant_fixed ? fixed_wb.rd_addr : long_wb.rd_addr;
  assign iwb_data_o = grant_fixed ? fixed_wb.data : long_wb.data;

  // A refused divider result stays on offer unchanged
  a_long_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (long_wb.v && !long_wb.ready) |=>
      (long_wb.v && $stable(long_wb.rd_addr) && $stable(long_wb.data)));

endmodule

// File: calc_wb_if.sv
//**************************************************************************
// Writeback channel. Transfer on a clock edge with v and ready both high;
// the producer holds v, rd_addr and data until then.
//**************************************************************************
`timescale 1ns/1ps
`include "calc_params.svh"

interface calc_wb_if;
  logic                    v;
  logic                    ready;
  logic [`CALC_REG_AW-1:0] rd_addr;
  logic [`CALC_XLEN-1:0]   data;

  modport producer (output v, rd_addr, data, input ready);
  modport consumer (input v, rd_addr, data, output ready);
endinterface

// File: compile.f
+incdir+.
calc_pkg.sv
calc_wb_if.sv
calc_fwd_if.sv
calc_issue.sv
calc_exe_pipe.sv
calc_long_div.sv
calc_wb_arbiter.sv
calc_top.sv
calc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the calc_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module calc_tb \
  -o calc_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/calc_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0
